/* tb.f */
common/mem_pkg.sv
boot/boot_loader.sv
ram1/ram1_uart_port.sv
ram2/ram2_port.sv
design/mem_router.sv
design/mem_system.sv
sim/sram_model.sv
sim/mem_system_tb.sv

/* sim/mem_system_tb.sv */
`timescale 1ns/1ps

module mem_system_tb;

	localparam int AW = mem_pkg::ADDR_W;
	localparam int DW = mem_pkg::DATA_W;
	localparam int BOOT_WORDS = 16;
	localparam int WAIT_LIMIT = 20;
	localparam int BOOT_LIMIT = 600;
	localparam logic [DW-1:0] RAM1_KEY = 16'h3C5A;
	localparam logic [DW-1:0] RAM2_KEY = 16'hC3A5;
	localparam logic [AW-1:0] UART_DATA_ADDR = {mem_pkg::IO_PAGE, mem_pkg::UART_DATA_REG};
	localparam logic [AW-1:0] UART_STAT_ADDR = {mem_pkg::IO_PAGE, mem_pkg::UART_STAT_REG};

	logic                             clk;
	logic                             rst_n;
	logic                             if_req;
	logic [AW-1:0]                    if_pc;
	logic [DW-1:0]                    if_inst;
	logic                             if_done;
	logic                             exe_rd;
	logic                             exe_wr;
	logic [AW-1:0]                    exe_addr;
	logic [DW-1:0]                    exe_wdata;
	logic [DW-1:0]                    exe_rdata;
	logic                             exe_done;
	logic                             hold;
	logic                             boot_done;
	logic [mem_pkg::FLASH_ADDR_W-1:0] flash_addr;
	logic                             flash_rd;
	logic [DW-1:0]                    flash_data = '0;
	logic                             flash_ready = 1'b0;
	logic [mem_pkg::SRAM_ADDR_W-1:0]  ram1_addr;
	logic [DW-1:0]                    ram1_wdata;
	logic [DW-1:0]                    ram1_rdata;
	logic [DW-1:0]                    sram1_rdata;
	logic                             ram1_en;
	logic                             ram1_oe;
	logic                             ram1_we;
	logic [mem_pkg::SRAM_ADDR_W-1:0]  ram2_addr;
	logic [DW-1:0]                    ram2_wdata;
	logic [DW-1:0]                    ram2_rdata;
	logic                             ram2_en;
	logic                             ram2_oe;
	logic                             ram2_we;
	logic                             data_ready;
	logic                             rdn;
	logic                             tbre;
	logic                             tsre;
	logic                             wrn;

	// Flash, UART and reference model state
	logic [DW-1:0] flash_img [0:BOOT_WORDS-1];
	int            flash_delay [0:BOOT_WORDS-1];
	int            flash_wait = 0;
	logic [DW-1:0] uart_rx_word;
	logic [7:0]    uart_tx_q [$];
	logic [DW-1:0] ram1_ref [0:65535];
	logic [DW-1:0] ram2_ref [0:65535];

	int errors;
	int checks;
	int tests_run;
	int tests_bad;
	bit timed_out;

	mem_system #(
		.BOOT_WORDS(BOOT_WORDS)
	) uut (
		.clk, .rst_n,
		.if_req, .if_pc, .if_inst, .if_done,
		.exe_rd, .exe_wr, .exe_addr, .exe_wdata, .exe_rdata, .exe_done,
		.hold, .boot_done,
		.flash_addr, .flash_rd, .flash_data, .flash_ready,
		.ram1_addr, .ram1_wdata, .ram1_rdata, .ram1_en, .ram1_oe, .ram1_we,
		.ram2_addr, .ram2_wdata, .ram2_rdata, .ram2_en, .ram2_oe, .ram2_we,
		.data_ready, .rdn, .tbre, .tsre, .wrn
	);

	sram_model #(
		.ADDR_W(mem_pkg::SRAM_ADDR_W),
		.DATA_W(DW),
		.FILL_KEY(RAM1_KEY)
	) ram1_mem (
		.clk, .addr(ram1_addr), .wdata(ram1_wdata), .rdata(sram1_rdata),
		.en(ram1_en), .oe(ram1_oe), .we(ram1_we)
	);

	sram_model #(
		.ADDR_W(mem_pkg::SRAM_ADDR_W),
		.DATA_W(DW),
		.FILL_KEY(RAM2_KEY)
	) ram2_mem (
		.clk, .addr(ram2_addr), .wdata(ram2_wdata), .rdata(ram2_rdata),
		.en(ram2_en), .oe(ram2_oe), .we(ram2_we)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Flash answers each read after its own delay
	always @(negedge clk) begin
		flash_ready <= 1'b0;
		if (!rst_n) begin
			flash_wait <= 0;
		end else if (flash_rd) begin
			flash_wait <= flash_delay[flash_addr];
			flash_data <= flash_img[flash_addr];
		end else if (flash_wait != 0) begin
			flash_wait <= flash_wait - 1;
			if (flash_wait == 1)
				flash_ready <= 1'b1;
		end
	end

	// UART receiver shares the RAM1 data lines
	assign ram1_rdata = rdn ? sram1_rdata : uart_rx_word;

	always @(posedge wrn) begin
		if (rst_n)
			uart_tx_q.push_back(ram1_wdata[7:0]);
	end

	task automatic compare_word(input string what, input logic [DW-1:0] got,
			input logic [DW-1:0] expected);
		checks++;
		assert (got === expected) else begin
			errors++;
			$display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic confirm(input string what, input bit ok);
		checks++;
		assert (ok) else begin
			errors++;
			$display("** Error at %0t ns: %s", $time, what);
		end
	endtask

	task automatic report_test(input string name, input int start_errors);
		tests_run++;
		if (errors == start_errors) begin
			$display("%s: ok", name);
		end else begin
			tests_bad++;
			$display("%s: %0d errors", name, errors - start_errors);
		end
	endtask

	task automatic exe_access(input bit wr, input logic [AW-1:0] addr,
			input logic [DW-1:0] wdata, output logic [DW-1:0] rdata,
			output int lat, output time done_at);
		int  n;
		bit  seen;
		@(negedge clk);
		exe_rd = !wr;
		exe_wr = wr;
		exe_addr = addr;
		exe_wdata = wdata;
		n = 0;
		seen = 1'b0;
		rdata = 'x;
		lat = -1;
		done_at = 0;
		while (!seen && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
			seen = exe_done;
			confirm("hold did not follow the pending execute access", hold === !seen);
		end
		if (seen) begin
			rdata = exe_rdata;
			lat = n - 1;
			done_at = $time;
		end else begin
			timed_out = 1'b1;
			errors++;
			$display("Timeout: no exe_done within %0d cycles for address %h", WAIT_LIMIT, addr);
		end
		// Level stays up through the done cycle
		@(negedge clk);
		exe_rd = 1'b0;
		exe_wr = 1'b0;
	endtask

	task automatic fetch_word(input logic [AW-1:0] pc, output logic [DW-1:0] inst,
			output int lat, output time done_at);
		int  n;
		bit  seen;
		@(negedge clk);
		if_req = 1'b1;
		if_pc = pc;
		n = 0;
		seen = 1'b0;
		inst = 'x;
		lat = -1;
		done_at = 0;
		while (!seen && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
			seen = if_done;
		end
		if (seen) begin
			inst = if_inst;
			lat = n - 1;
			done_at = $time;
		end else begin
			timed_out = 1'b1;
			errors++;
			$display("Timeout: no if_done within %0d cycles for pc %h", WAIT_LIMIT, pc);
		end
		@(negedge clk);
		if_req = 1'b0;
	endtask

	task automatic boot_copy();
		int            start_errors;
		int            n;
		int            lat;
		time           t;
		logic [DW-1:0] inst;
		start_errors = errors;
		n = 0;
		while (boot_done !== 1'b1 && n < BOOT_LIMIT) begin
			confirm("hold was low before boot_done", hold === 1'b1);
			@(negedge clk);
			n++;
		end
		if (boot_done !== 1'b1) begin
			timed_out = 1'b1;
			errors++;
			$display("Timeout: boot_done did not rise within %0d cycles", BOOT_LIMIT);
		end else begin
			confirm("hold stayed high after boot_done", hold === 1'b0);
			for (int i = 0; i < BOOT_WORDS && !timed_out; i++) begin
				fetch_word(AW'(i), inst, lat, t);
				compare_word($sformatf("boot word %0d", i), inst, flash_img[i]);
			end
		end
		report_test("boot copy", start_errors);
	endtask

	task automatic ram1_random();
		int            start_errors;
		int            lat;
		time           t;
		bit            wr;
		logic [AW-1:0] pool [0:7];
		logic [AW-1:0] a;
		logic [DW-1:0] d;
		logic [DW-1:0] got;
		start_errors = errors;
		for (int i = 0; i < 8; i++) begin
			a = mem_pkg::RAM1_BASE | AW'($urandom_range(0, 16'h7FFF));
			// Stay off the UART page
			if (a[AW-1:8] == mem_pkg::IO_PAGE)
				a[8] = 1'b0;
			pool[i] = a;
		end
		for (int k = 0; k < 40 && !timed_out; k++) begin
			a = pool[$urandom_range(0, 7)];
			wr = $urandom_range(0, 1);
			d = DW'($urandom);
			exe_access(wr, a, d, got, lat, t);
			compare_word("RAM1 latency in cycles", DW'(lat), DW'(2));
			if (wr)
				ram1_ref[a] = d;
			else
				compare_word($sformatf("RAM1 read at %h", a), got, ram1_ref[a]);
		end
		report_test("RAM1 access", start_errors);
	endtask

	task automatic program_space();
		int            start_errors;
		int            lat;
		int            op;
		time           t;
		logic [AW-1:0] pool [0:5];
		logic [AW-1:0] a;
		logic [DW-1:0] d;
		logic [DW-1:0] got;
		start_errors = errors;
		for (int i = 0; i < 6; i++)
			pool[i] = AW'($urandom_range(0, 16'h7FFF));
		for (int k = 0; k < 42 && !timed_out; k++) begin
			// Every address written once before the random mix
			op = (k < 6) ? 0 : $urandom_range(0, 2);
			a = (k < 6) ? pool[k] : pool[$urandom_range(0, 5)];
			d = DW'($urandom);
			if (op == 2) begin
				fetch_word(a, got, lat, t);
				compare_word($sformatf("fetch at %h", a), got, ram2_ref[a]);
			end else begin
				exe_access(op == 0, a, d, got, lat, t);
				if (op == 0)
					ram2_ref[a] = d;
				else
					compare_word($sformatf("program read at %h", a), got, ram2_ref[a]);
			end
			compare_word("RAM2 latency in cycles", DW'(lat), DW'(2));
		end
		report_test("program space", start_errors);
	endtask

	task automatic uart_registers();
		int            start_errors;
		int            lat;
		int            writes_before;
		time           t;
		logic [7:0]    sent;
		logic [DW-1:0] d;
		logic [DW-1:0] got;
		logic [DW-1:0] status;
		start_errors = errors;
		uart_tx_q.delete();
		for (int k = 0; k < 8 && !timed_out; k++) begin
			@(negedge clk);
			tbre = $urandom_range(0, 1);
			tsre = $urandom_range(0, 1);
			data_ready = $urandom_range(0, 1);
			status = '0;
			status[0] = tbre && tsre;
			status[1] = data_ready;
			exe_access(1'b0, UART_STAT_ADDR, '0, got, lat, t);
			compare_word("UART status", got, status);
		end
		for (int k = 0; k < 6 && !timed_out; k++) begin
			@(negedge clk);
			uart_rx_word = DW'($urandom);
			exe_access(1'b0, UART_DATA_ADDR, '0, got, lat, t);
			compare_word("UART receive byte", got, {8'h00, uart_rx_word[7:0]});
		end
		for (int k = 0; k < 6 && !timed_out; k++) begin
			d = DW'($urandom);
			writes_before = ram1_mem.wr_count;
			exe_access(1'b1, UART_DATA_ADDR, d, got, lat, t);
			confirm("UART write did not deliver exactly one byte", uart_tx_q.size() == 1);
			if (uart_tx_q.size() > 0) begin
				sent = uart_tx_q.pop_front();
				compare_word("UART transmit byte", {8'h00, sent}, {8'h00, d[7:0]});
			end
			confirm("UART write also wrote RAM1", ram1_mem.wr_count == writes_before);
		end
		report_test("UART registers", start_errors);
	endtask

	task automatic fetch_contention();
		int            start_errors;
		int            lat_exe;
		int            lat_if;
		time           t_exe;
		time           t_if;
		bit            wr;
		logic [AW-1:0] pool [0:3];
		logic [AW-1:0] a;
		logic [AW-1:0] b;
		logic [DW-1:0] d;
		logic [DW-1:0] old_word;
		logic [DW-1:0] got_exe;
		logic [DW-1:0] got_if;
		start_errors = errors;
		for (int i = 0; i < 4; i++)
			pool[i] = AW'($urandom_range(0, 16'h7FFF));
		for (int k = 0; k < 10 && !timed_out; k++) begin
			a = pool[$urandom_range(0, 3)];
			b = pool[$urandom_range(0, 3)];
			wr = $urandom_range(0, 1);
			d = DW'($urandom);
			old_word = ram2_ref[a];
			fork
				exe_access(wr, a, d, got_exe, lat_exe, t_exe);
				fetch_word(b, got_if, lat_if, t_if);
			join
			if (wr)
				ram2_ref[a] = d;
			else
				compare_word("execute read under contention", got_exe, old_word);
			compare_word("fetch under contention", got_if, ram2_ref[b]);
			compare_word("execute latency under contention", DW'(lat_exe), DW'(2));
			confirm("fetch finished before the execute access", t_exe < t_if);
			confirm("hold still high after the execute access", hold === 1'b0);
		end
		report_test("fetch contention", start_errors);
	endtask

	initial begin
		void'($urandom(59699));
		rst_n = 1'b0;
		if_req = 1'b0;
		if_pc = '0;
		exe_rd = 1'b0;
		exe_wr = 1'b0;
		exe_addr = '0;
		exe_wdata = '0;
		data_ready = 1'b0;
		tbre = 1'b1;
		tsre = 1'b1;
		uart_rx_word = '0;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_bad = 0;
		timed_out = 1'b0;
		for (int i = 0; i < 65536; i++) begin
			ram1_ref[i] = AW'(i) ^ RAM1_KEY;
			ram2_ref[i] = AW'(i) ^ RAM2_KEY;
		end
		for (int i = 0; i < BOOT_WORDS; i++) begin
			flash_img[i] = DW'($urandom);
			flash_delay[i] = $urandom_range(1, 6);
			ram2_ref[i] = flash_img[i];
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		boot_copy();
		if (!timed_out)
			ram1_random();
		if (!timed_out)
			program_space();
		if (!timed_out)
			uart_registers();
		if (!timed_out)
			fetch_contention();

		$display("Tests run %0d, with errors %0d, checks %0d, errors %0d",
			tests_run, tests_bad, checks, errors);
		if (errors == 0 && !timed_out)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* sim/sram_model.sv */
`timescale 1ns/1ps

module sram_model #(
	parameter int ADDR_W = 18,
	parameter int DATA_W = 16,
	parameter logic [DATA_W-1:0] FILL_KEY = '0
) (
	input  logic              clk,
	input  logic [ADDR_W-1:0] addr,
	input  logic [DATA_W-1:0] wdata,
	output logic [DATA_W-1:0] rdata,
	input  logic              en,
	input  logic              oe,
	input  logic              we
);

	localparam int DEPTH = 2 ** ADDR_W;

	logic [DATA_W-1:0] mem [0:DEPTH-1];
	int                wr_count = 0;

	// Every word starts from its own full address
	initial begin
		for (int a = 0; a < DEPTH; a++)
			mem[a] = DATA_W'(a) ^ DATA_W'((a >> DATA_W) * 16'h1111) ^ FILL_KEY;
	end

	// Write lands on the clock while both strobes are low
	always @(posedge clk) begin
		if (!en && !we) begin
			mem[addr] <= wdata;
			wr_count <= wr_count + 1;
		end
	end

	assign rdata = (!en && !oe) ? mem[addr] : '0;

endmodule

/* design/mem_system.sv */
`timescale 1ns/1ps

module mem_system #(
	parameter int BOOT_WORDS = 16
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             if_req,
	input  logic [mem_pkg::ADDR_W-1:0]       if_pc,
	output logic [mem_pkg::DATA_W-1:0]       if_inst,
	output logic                             if_done,
	input  logic                             exe_rd,
	input  logic                             exe_wr,
	input  logic [mem_pkg::ADDR_W-1:0]       exe_addr,
	input  logic [mem_pkg::DATA_W-1:0]       exe_wdata,
	output logic [mem_pkg::DATA_W-1:0]       exe_rdata,
	output logic                             exe_done,
	output logic                             hold,
	output logic                             boot_done,
	output logic [mem_pkg::FLASH_ADDR_W-1:0] flash_addr,
	output logic                             flash_rd,
	input  logic [mem_pkg::DATA_W-1:0]       flash_data,
	input  logic                             flash_ready,
	output logic [mem_pkg::SRAM_ADDR_W-1:0]  ram1_addr,
	output logic [mem_pkg::DATA_W-1:0]       ram1_wdata,
	input  logic [mem_pkg::DATA_W-1:0]       ram1_rdata,
	output logic                             ram1_en,
	output logic                             ram1_oe,
	output logic                             ram1_we,
	output logic [mem_pkg::SRAM_ADDR_W-1:0]  ram2_addr,
	output logic [mem_pkg::DATA_W-1:0]       ram2_wdata,
	input  logic [mem_pkg::DATA_W-1:0]       ram2_rdata,
	output logic                             ram2_en,
	output logic                             ram2_oe,
	output logic                             ram2_we,
	input  logic                             data_ready,
	output logic                             rdn,
	input  logic                             tbre,
	input  logic                             tsre,
	output logic                             wrn
);

	// Boot path into RAM2
	logic                       init_wr;
	logic [mem_pkg::ADDR_W-1:0] init_addr;
	logic [mem_pkg::DATA_W-1:0] init_data;
	logic                       init_done;

	// Router to data channel
	logic                       r1_rd;
	logic                       r1_wr;
	mem_pkg::data_addr_u        r1_addr;
	logic [mem_pkg::DATA_W-1:0] r1_wdata;
	logic [mem_pkg::DATA_W-1:0] r1_rdata;
	logic                       r1_done;

	// Router to program channel
	logic                       r2_rd;
	logic                       r2_wr;
	logic [mem_pkg::ADDR_W-1:0] r2_addr;
	logic [mem_pkg::DATA_W-1:0] r2_wdata;
	logic [mem_pkg::DATA_W-1:0] r2_rdata;
	logic                       r2_done;

	boot_loader #(
		.BOOT_WORDS(BOOT_WORDS)
	) u_boot_loader (
		.clk, .rst_n,
		.flash_rd, .flash_addr, .flash_ready, .flash_data,
		.init_wr, .init_addr, .init_data, .init_done,
		.boot_done
	);

	mem_router u_mem_router (
		.clk, .rst_n, .boot_done,
		.exe_rd, .exe_wr, .exe_addr, .exe_wdata, .exe_rdata, .exe_done, .hold,
		.ram1_rd(r1_rd),
		.ram1_wr(r1_wr),
		.ram1_addr(r1_addr),
		.ram1_wdata(r1_wdata),
		.ram1_rdata(r1_rdata),
		.ram1_done(r1_done),
		.ram2_rd(r2_rd),
		.ram2_wr(r2_wr),
		.ram2_addr(r2_addr),
		.ram2_wdata(r2_wdata),
		.ram2_rdata(r2_rdata),
		.ram2_done(r2_done)
	);

	ram1_uart_port u_ram1_uart_port (
		.clk, .rst_n,
		.req_rd(r1_rd),
		.req_wr(r1_wr),
		.addr(r1_addr),
		.wdata(r1_wdata),
		.rdata(r1_rdata),
		.done(r1_done),
		.ram1_addr, .ram1_wdata, .ram1_rdata, .ram1_en, .ram1_oe, .ram1_we,
		.data_ready, .rdn, .tbre, .tsre, .wrn
	);

	ram2_port u_ram2_port (
		.clk, .rst_n,
		.init_wr, .init_addr, .init_data, .init_done,
		.exe_req_rd(r2_rd),
		.exe_req_wr(r2_wr),
		.exe_addr(r2_addr),
		.exe_wdata(r2_wdata),
		.exe_rdata(r2_rdata),
		.exe_done(r2_done),
		.if_req, .if_pc, .if_inst, .if_done,
		.ram2_addr, .ram2_wdata, .ram2_rdata, .ram2_en, .ram2_oe, .ram2_we
	);

endmodule

/* design/mem_router.sv */
`timescale 1ns/1ps

module mem_router (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       boot_done,
	input  logic                       exe_rd,
	input  logic                       exe_wr,
	input  logic [mem_pkg::ADDR_W-1:0] exe_addr,
	input  logic [mem_pkg::DATA_W-1:0] exe_wdata,
	output logic [mem_pkg::DATA_W-1:0] exe_rdata,
	output logic                       exe_done,
	output logic                       hold,
	output logic                       ram1_rd,
	output logic                       ram1_wr,
	output mem_pkg::data_addr_u        ram1_addr,
	output logic [mem_pkg::DATA_W-1:0] ram1_wdata,
	input  logic [mem_pkg::DATA_W-1:0] ram1_rdata,
	input  logic                       ram1_done,
	output logic                       ram2_rd,
	output logic                       ram2_wr,
	output logic [mem_pkg::ADDR_W-1:0] ram2_addr,
	output logic [mem_pkg::DATA_W-1:0] ram2_wdata,
	input  logic [mem_pkg::DATA_W-1:0] ram2_rdata,
	input  logic                       ram2_done
);

	logic sel_ram1;
	logic exe_any;

	// Upper half of data space is RAM1 and the UART page
	assign sel_ram1 = (exe_addr >= mem_pkg::RAM1_BASE);
	assign exe_any = exe_rd || exe_wr;

	assign ram1_rd = boot_done && exe_rd && sel_ram1;
	assign ram1_wr = boot_done && exe_wr && sel_ram1;
	assign ram2_rd = boot_done && exe_rd && !sel_ram1;
	assign ram2_wr = boot_done && exe_wr && !sel_ram1;

	assign ram1_addr = exe_addr;
	assign ram1_wdata = exe_wdata;
	assign ram2_addr = exe_addr;
	assign ram2_wdata = exe_wdata;

	assign exe_done = sel_ram1 ? ram1_done : ram2_done;
	assign exe_rdata = sel_ram1 ? ram1_rdata : ram2_rdata;

	// Pipeline frozen during boot and while an access is pending
	assign hold = !boot_done || (exe_any && !exe_done);

	a_one_channel: assert property (@(posedge clk) disable iff (!rst_n)
		!((ram1_rd || ram1_wr) && (ram2_rd || ram2_wr)));

	// A channel only answers a request that is still held
	a_done_has_req: assert property (@(posedge clk) disable iff (!rst_n)
		exe_done |-> exe_any && boot_done);

endmodule

/* ram2/ram2_port.sv */
`timescale 1ns/1ps

module ram2_port (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            init_wr,
	input  logic [mem_pkg::ADDR_W-1:0]      init_addr,
	input  logic [mem_pkg::DATA_W-1:0]      init_data,
	output logic                            init_done,
	input  logic                            exe_req_rd,
	input  logic                            exe_req_wr,
	input  logic [mem_pkg::ADDR_W-1:0]      exe_addr,
	input  logic [mem_pkg::DATA_W-1:0]      exe_wdata,
	output logic [mem_pkg::DATA_W-1:0]      exe_rdata,
	output logic                            exe_done,
	input  logic                            if_req,
	input  logic [mem_pkg::ADDR_W-1:0]      if_pc,
	output logic [mem_pkg::DATA_W-1:0]      if_inst,
	output logic                            if_done,
	output logic [mem_pkg::SRAM_ADDR_W-1:0] ram2_addr,
	output logic [mem_pkg::DATA_W-1:0]      ram2_wdata,
	input  logic [mem_pkg::DATA_W-1:0]      ram2_rdata,
	output logic                            ram2_en,
	output logic                            ram2_oe,
	output logic                            ram2_we
);

	localparam int G_BOOT = 0;
	localparam int G_EXE  = 1;
	localparam int G_IF   = 2;

	logic [2:0]                   req;
	logic [2:0]                   grant;
	logic [2:0]                   dn;
	logic                         phase;
	logic                         busy;
	logic                         acc_wr;
	logic [mem_pkg::ADDR_W-1:0]   acc_addr;
	logic [mem_pkg::DATA_W-1:0]   acc_wdata;
	logic [mem_pkg::DATA_W-1:0]   rd_word;

	// Mask a requester in its own done cycle
	assign req = {if_req, exe_req_rd | exe_req_wr, init_wr} & ~dn;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			grant <= '0;
			phase <= 1'b0;
			dn <= '0;
		end else begin
			dn <= '0;
			if (grant == '0) begin
				phase <= 1'b0;
				if (req[G_BOOT])
					grant[G_BOOT] <= 1'b1;
				else if (req[G_EXE])
					grant[G_EXE] <= 1'b1;
				else if (req[G_IF])
					grant[G_IF] <= 1'b1;
			end else if (!phase) begin
				phase <= 1'b1;
			end else begin
				grant <= '0;
				phase <= 1'b0;
				dn <= grant;
			end
		end
	end

	always_comb begin
		acc_addr = if_pc;
		acc_wdata = exe_wdata;
		acc_wr = 1'b0;
		if (grant[G_BOOT]) begin
			acc_addr = init_addr;
			acc_wdata = init_data;
			acc_wr = 1'b1;
		end else if (grant[G_EXE]) begin
			acc_addr = exe_addr;
			acc_wr = exe_req_wr;
		end
	end

	// Read word taken at the end of the second cycle
	always_ff @(posedge clk) begin
		if (phase && !acc_wr)
			rd_word <= ram2_rdata;
	end

	assign busy = |grant;

	assign ram2_addr = {{(mem_pkg::SRAM_ADDR_W - mem_pkg::ADDR_W){1'b0}}, acc_addr};
	assign ram2_wdata = acc_wdata;
	assign ram2_en = !busy;
	assign ram2_oe = !(busy && !acc_wr);
	assign ram2_we = !(busy && acc_wr);

	assign init_done = dn[G_BOOT];
	assign exe_done = dn[G_EXE];
	assign if_done = dn[G_IF];
	assign exe_rdata = rd_word;
	assign if_inst = rd_word;

	a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(grant));

endmodule

/* ram1/ram1_uart_port.sv */
`timescale 1ns/1ps

module ram1_uart_port (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            req_rd,
	input  logic                            req_wr,
	input  mem_pkg::data_addr_u             addr,
	input  logic [mem_pkg::DATA_W-1:0]      wdata,
	output logic [mem_pkg::DATA_W-1:0]      rdata,
	output logic                            done,
	output logic [mem_pkg::SRAM_ADDR_W-1:0] ram1_addr,
	output logic [mem_pkg::DATA_W-1:0]      ram1_wdata,
	input  logic [mem_pkg::DATA_W-1:0]      ram1_rdata,
	output logic                            ram1_en,
	output logic                            ram1_oe,
	output logic                            ram1_we,
	input  logic                            data_ready,
	output logic                            rdn,
	input  logic                            tbre,
	input  logic                            tsre,
	output logic                            wrn
);

	localparam int DW = mem_pkg::DATA_W;

	logic          busy;
	logic          phase;
	logic          op_wr;
	logic          op_sram;
	logic          op_uart;
	logic          op_stat;
	logic          is_io;
	logic          sram_act;
	logic          uart_act;
	logic [DW-1:0] status_word;

	assign is_io = (addr.io.page == mem_pkg::IO_PAGE);

	// Two strobe cycles per access, done right after the second
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			phase <= 1'b0;
			done <= 1'b0;
			op_wr <= 1'b0;
			op_sram <= 1'b0;
			op_uart <= 1'b0;
			op_stat <= 1'b0;
		end else begin
			done <= 1'b0;
			if (!busy) begin
				// Level is still up during the done cycle
				if ((req_rd || req_wr) && !done) begin
					busy <= 1'b1;
					phase <= 1'b0;
					op_wr <= req_wr;
					op_sram <= !is_io;
					op_uart <= is_io && (addr.io.regnum == mem_pkg::UART_DATA_REG);
					op_stat <= is_io && (addr.io.regnum == mem_pkg::UART_STAT_REG);
				end
			end else if (!phase) begin
				phase <= 1'b1;
			end else begin
				busy <= 1'b0;
				phase <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	assign status_word = {{(DW - 2){1'b0}}, data_ready, tbre & tsre};

	always_ff @(posedge clk) begin
		if (busy && phase && !op_wr) begin
			if (op_sram)
				rdata <= ram1_rdata;
			else if (op_uart)
				rdata <= {{(DW - 8){1'b0}}, ram1_rdata[7:0]};
			else if (op_stat)
				rdata <= status_word;
			else
				rdata <= '0;
		end
	end

	assign sram_act = busy && op_sram;
	assign uart_act = busy && op_uart;

	assign ram1_addr = {{(mem_pkg::SRAM_ADDR_W - mem_pkg::ADDR_W){1'b0}}, addr.flat};
	assign ram1_wdata = op_uart ? {{(DW - 8){1'b0}}, wdata[7:0]} : wdata;
	assign ram1_en = !sram_act;
	assign ram1_oe = !(sram_act && !op_wr);
	assign ram1_we = !(sram_act && op_wr);

	// UART shares the RAM1 data lines
	assign rdn = !(uart_act && !op_wr);
	assign wrn = !(uart_act && op_wr);

	a_bus_owner: assert property (@(posedge clk) disable iff (!rst_n)
		(rdn || wrn) && (ram1_en || (rdn && wrn)));

endmodule

/* boot/boot_loader.sv */
`timescale 1ns/1ps

module boot_loader #(
	parameter int BOOT_WORDS = 16
) (
	input  logic                             clk,
	input  logic                             rst_n,
	output logic                             flash_rd,
	output logic [mem_pkg::FLASH_ADDR_W-1:0] flash_addr,
	input  logic                             flash_ready,
	input  logic [mem_pkg::DATA_W-1:0]       flash_data,
	output logic                             init_wr,
	output logic [mem_pkg::ADDR_W-1:0]       init_addr,
	output logic [mem_pkg::DATA_W-1:0]       init_data,
	input  logic                             init_done,
	output logic                             boot_done
);

	localparam int AW = mem_pkg::ADDR_W;
	localparam logic [AW-1:0] LAST_WORD = AW'(BOOT_WORDS - 1);

	localparam logic [2:0] ST_START = 3'd0;
	localparam logic [2:0] ST_REQ   = 3'd1;
	localparam logic [2:0] ST_WAIT  = 3'd2;
	localparam logic [2:0] ST_WRITE = 3'd3;
	localparam logic [2:0] ST_DONE  = 3'd4;

	logic [2:0]    state;
	logic [AW-1:0] word_idx;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_START;
			word_idx <= '0;
		end else begin
			case (state)
				ST_START: state <= ST_REQ;
				ST_REQ: state <= ST_WAIT;
				ST_WAIT: begin
					if (flash_ready)
						state <= ST_WRITE;
				end
				ST_WRITE: begin
					if (init_done) begin
						if (word_idx == LAST_WORD) begin
							state <= ST_DONE;
						end else begin
							word_idx <= word_idx + 1'b1;
							state <= ST_REQ;
						end
					end
				end
				default: state <= ST_DONE;
			endcase
		end
	end

	// Flash word held until RAM2 has taken it
	always_ff @(posedge clk) begin
		if (state == ST_WAIT && flash_ready)
			init_data <= flash_data;
	end

	assign flash_rd = (state == ST_REQ);
	assign flash_addr = {{(mem_pkg::FLASH_ADDR_W - AW){1'b0}}, word_idx};
	assign init_wr = (state == ST_WRITE);
	assign init_addr = word_idx;
	assign boot_done = (state == ST_DONE);

	// One flash read in flight at a time
	a_single_flash_read: assert property (@(posedge clk) disable iff (!rst_n)
		flash_rd |=> (!flash_rd until flash_ready));

endmodule

/* common/mem_pkg.sv */
package mem_pkg;

	// Processor word space and memory word
	localparam int ADDR_W = 16;
	localparam int DATA_W = 16;

	// Board pin widths
	localparam int SRAM_ADDR_W = 18;
	localparam int FLASH_ADDR_W = 22;

	// Data space map
	localparam logic [ADDR_W-1:0] RAM1_BASE = 16'h8000;
	localparam logic [7:0] IO_PAGE = 8'hBF;

	// UART registers inside the I/O page
	localparam logic [7:0] UART_DATA_REG = 8'h00;
	localparam logic [7:0] UART_STAT_REG = 8'h01;

	// One data address, seen flat or as page and register
	typedef union packed {
		logic [ADDR_W-1:0] flat;
		struct packed {
			logic [7:0] page;
			logic [7:0] regnum;
		} io;
	} data_addr_u;

endpackage
